// File: compile.f
hdl/snn_pkg.sv
hdl/network_source.sv
hdl/neuron_config_regs.sv
hdl/neuron_layer.sv
hdl/spike_counter.sv
hdl/snn_top.sv
verif/snn_checker.sv
verif/snn_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module snn_tb -f compile.f -o snn_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snn_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// File: verif/snn_tb.sv
`timescale 1ns/1ps

module snn_tb;

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    snn_pkg::src_word_t src;
    logic cfg_we;
    snn_pkg::cfg_addr_t cfg_addr;
    snn_pkg::cfg_data_t cfg_wdata;
    snn_pkg::spk_vec_t spikes;
    logic res_ready;
    logic res_valid;
    snn_pkg::count_vec_t res_counts;
    logic res_overrun;

    // one table row, either a config write or a source word
    typedef struct packed {
        logic [2:0] test;
        logic is_cfg;
        // result left unacknowledged
        logic hold;
        // expected spikes taken from the model, not from exp_spk
        logic from_model;
        snn_pkg::spk_vec_t exp_spk;
        snn_pkg::cfg_addr_t addr;
        snn_pkg::src_word_t data;
    } step_t;

    step_t steps[$];
    string names[6] = '{"reset", "integrate", "mask_thr", "clear_word", "dump_word", "random"};
    int test_errs[6];
    int errors;
    bit timed_out;
    logic [31:0] rng;

    // reference model of the network
    int pot_m[4];
    int thr_m[4];
    logic [3:0] mask_m[4];
    int cnt_m[4];
    bit pend_m;
    bit ovr_m;

    snn_top DUT (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .spikes(spikes),
        .res_ready(res_ready),
        .res_valid(res_valid),
        .res_counts(res_counts),
        .res_overrun(res_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // flags on top, charge 0 right below them
    function automatic snn_pkg::src_word_t make_word(input bit clr, input bit dec,
        input int c0, input int c1, input int c2, input int c3);
        return {clr, dec, 8'(c0), 8'(c1), 8'(c2), 8'(c3)};
    endfunction

    function automatic void add_word(input int t, input snn_pkg::src_word_t w,
        input snn_pkg::spk_vec_t e, input bit hold = 1'b0, input bit from_model = 1'b0);
        step_t s;
        s = '0;
        s.test = 3'(t);
        s.data = w;
        s.exp_spk = e;
        s.hold = hold;
        s.from_model = from_model;
        steps.push_back(s);
    endfunction

    function automatic void add_cfg(input int t, input int a, input logic [11:0] d);
        step_t s;
        s = '0;
        s.test = 3'(t);
        s.is_cfg = 1'b1;
        s.addr = 3'(a);
        s.data = {22'd0, d};
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        logic [31:0] c;
        bit clr;
        bit dec;
        add_word(0, make_word(0, 1, 0, 0, 0, 0), 4'h0);
        // all neurons alike, threshold 64
        add_word(1, make_word(0, 0, 10, 10, 5, 5), 4'h0);
        add_word(1, make_word(0, 0, 10, 10, 5, 5), 4'h0);
        add_word(1, make_word(0, 0, 10, 10, 5, 5), 4'hf);
        add_word(1, make_word(0, 0, 16, 16, 16, 15), 4'h0);
        add_word(1, make_word(0, 0, 1, 0, 0, 0), 4'hf);
        add_word(1, make_word(0, 0, -20, 0, 0, 0), 4'h0);
        add_word(1, make_word(0, 0, 20, 0, 0, 0), 4'h0);
        // negative threshold write is stored as 1
        add_cfg(2, 0, 12'd10);
        add_cfg(2, 1, 12'd30);
        add_cfg(2, 2, 12'hff0);
        add_cfg(2, 3, 12'd100);
        add_cfg(2, 4, 12'h001);
        add_cfg(2, 5, 12'h003);
        add_cfg(2, 6, 12'h008);
        add_cfg(2, 7, 12'h00f);
        add_word(2, make_word(0, 0, 10, 5, 3, -2), 4'h1);
        add_word(2, make_word(0, 0, 5, 20, 3, 4), 4'h6);
        add_word(2, make_word(0, 0, 5, 0, 0, 0), 4'h1);
        add_word(2, make_word(0, 0, 20, 20, 7, 0), 4'hb);
        // neuron 3 parks at 99, the clear throws that away
        add_word(3, make_word(0, 0, 30, 30, 30, 9), 4'h7);
        add_word(3, make_word(1, 0, 0, 0, 0, 1), 4'h4);
        add_word(3, make_word(0, 0, 0, 0, 0, 98), 4'h4);
        add_word(3, make_word(0, 0, 0, 0, 0, 1), 4'hc);
        add_word(4, make_word(0, 1, 10, 30, 1, 0), 4'h3);
        add_word(4, make_word(0, 0, 0, 0, 0, 1), 4'h4);
        add_word(4, make_word(0, 1, 0, 0, 0, 0), 4'h0, 1'b1);
        add_word(4, make_word(0, 1, 0, 0, 0, 0), 4'h0, 1'b1);
        // neuron 3 only fires at the top of the range
        add_cfg(5, 3, 12'h7ff);
        for (int k = 0; k < 200; k++) begin
            rng = xorshift(rng);
            c = rng;
            // a negative run, then a strongly positive one
            if (k >= 60 && k < 120) c = c | 32'h80808080;
            if (k >= 140 && k < 170) c = (c & 32'h1f1f1f1f) | 32'h60606060;
            rng = xorshift(rng);
            clr = (rng[3:0] == 4'd0);
            dec = (rng[6:4] == 3'd0);
            add_word(5, {clr, dec, c}, 4'h0, 1'b0, 1'b1);
        end
    endfunction

    // steps every neuron through one vector and counts its spikes
    function automatic snn_pkg::spk_vec_t model_vector(input snn_pkg::src_word_t w);
        snn_pkg::spk_vec_t fired;
        logic [7:0] b;
        int ch[4];
        int sum;
        fired = '0;
        for (int i = 0; i < 4; i++) begin
            b = w[31 - 8*i -: 8];
            ch[i] = $signed(b);
        end
        for (int n = 0; n < 4; n++) begin
            sum = pot_m[n];
            for (int i = 0; i < 4; i++) begin
                if (mask_m[n][i]) sum += ch[i];
            end
            // 12-bit signed potential range
            if (sum > 2047) sum = 2047;
            if (sum < -2048) sum = -2048;
            fired[n] = (sum >= thr_m[n]);
            pot_m[n] = fired[n] ? 0 : sum;
            if (fired[n] && cnt_m[n] < 255) cnt_m[n]++;
        end
        return fired;
    endfunction

    task automatic report_mismatch(input int t, input string what, input logic [31:0] exp,
        input logic [31:0] act);
        $display("ERR %s %s expected %h actual %h", names[t], what, exp, act);
        test_errs[t]++;
        errors++;
    endtask

    // a stuck handshake ends the run early
    task automatic report_timeout(input int t, input string why);
        $display("%s %s", names[t], why);
        test_errs[t]++;
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic write_cfg(input step_t s);
        int thr;
        cfg_we = 1'b1;
        cfg_addr = s.addr;
        cfg_wdata = s.data[11:0];
        @(negedge clk);
        cfg_we = 1'b0;
        if (s.addr[2]) begin
            mask_m[s.addr[1:0]] = s.data[3:0];
        end else begin
            thr = $signed(s.data[11:0]);
            thr_m[s.addr[1:0]] = (thr < 1) ? 1 : thr;
        end
    endtask

    task automatic apply_word(input step_t s);
        snn_pkg::spk_vec_t exp;
        snn_pkg::count_vec_t exp_res;
        bit dump;
        bit flagged;
        int waits;
        src = s.data;
        src_valid = 1'b1;
        exp_res = '0;
        dump = s.data[snn_pkg::FLAG_DEC];
        flagged = dump | s.data[snn_pkg::FLAG_CLR];
        // clear and snapshot both act before the word's own vector
        if (s.data[snn_pkg::FLAG_CLR]) begin
            for (int n = 0; n < 4; n++) pot_m[n] = 0;
        end
        if (dump) begin
            for (int n = 0; n < 4; n++) begin
                exp_res[n*8 +: 8] = 8'(cnt_m[n]);
                cnt_m[n] = 0;
            end
            ovr_m = ovr_m | pend_m;
            pend_m = 1'b1;
        end
        waits = 0;
        #1;
        while (!src_ready) begin
            if (waits == 8) begin
                report_timeout(s.test, "timeout: src_ready never went high");
                return;
            end
            @(posedge clk);
            @(negedge clk);
            waits++;
        end
        // flagged words stall for exactly one cycle, plain words not at all
        if (waits != (flagged ? 1 : 0)) begin
            report_mismatch(s.test, "src_ready stall", flagged ? 1 : 0, waits);
        end
        // snapshot edge has passed, the result is already registered
        if (dump && res_valid !== 1'b1) report_mismatch(s.test, "res_valid", 1, res_valid);
        @(posedge clk);
        @(negedge clk);
        src_valid = 1'b0;
        exp = model_vector(s.data);
        if (!s.from_model) exp = s.exp_spk;
        if (spikes !== exp) report_mismatch(s.test, "spikes", exp, spikes);
        if (dump) begin
            waits = 0;
            while (!res_valid) begin
                if (waits == 8) begin
                    report_timeout(s.test, "timeout: res_valid never went high");
                    return;
                end
                @(negedge clk);
                waits++;
            end
            if (res_counts !== exp_res) report_mismatch(s.test, "res_counts", exp_res, res_counts);
            if (res_overrun !== ovr_m) report_mismatch(s.test, "res_overrun", ovr_m, res_overrun);
            if (!s.hold) begin
                res_ready = 1'b1;
                @(negedge clk);
                res_ready = 1'b0;
                pend_m = 1'b0;
            end
        end
    endtask

    task automatic report_test(input int t);
        $display("%-10s done, %0d errors", names[t], test_errs[t]);
    endtask

    initial begin
        int cur;
        arstn = 1'b0;
        src_valid = 1'b0;
        src = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        res_ready = 1'b0;
        errors = 0;
        timed_out = 1'b0;
        rng = 32'd21;
        pend_m = 1'b0;
        ovr_m = 1'b0;
        for (int n = 0; n < 4; n++) begin
            pot_m[n] = 0;
            thr_m[n] = 64;
            mask_m[n] = 4'hf;
            cnt_m[n] = 0;
        end
        build_table();
        repeat (8) @(negedge clk);
        arstn = 1'b1;
        @(negedge clk);
        if (src_ready !== 1'b1) report_mismatch(0, "src_ready", 1, src_ready);
        if (res_valid !== 1'b0) report_mismatch(0, "res_valid", 0, res_valid);
        if (res_overrun !== 1'b0) report_mismatch(0, "res_overrun", 0, res_overrun);
        if (spikes !== '0) report_mismatch(0, "spikes", 0, spikes);
        cur = 0;
        foreach (steps[k]) begin
            // nothing more is applied once a handshake has hung
            if (!timed_out) begin
                if (steps[k].test != cur) begin
                    report_test(cur);
                    cur = steps[k].test;
                end
                if (steps[k].is_cfg) begin
                    write_cfg(steps[k]);
                end else begin
                    apply_word(steps[k]);
                end
            end
        end
        report_test(cur);
        $display("tests 6, errors %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verif/snn_checker.sv
`timescale 1ns/1ps

module snn_checker (
    input logic clk,
    input logic arstn,
    input logic src_valid,
    input logic src_ready,
    input snn_pkg::src_word_t src,
    input logic net_valid,
    input logic net_clr,
    input logic res_valid,
    input logic res_ready,
    input snn_pkg::spk_vec_t spikes
);

    // a stalled word stays put until it is taken
    src_hold: assert property (@(posedge clk) disable iff (!arstn)
        src_valid && !src_ready |=> $stable(src))
        else $error("src changed while stalled");

    // clear and apply always fall in different cycles
    clr_apart: assert property (@(posedge clk) disable iff (!arstn)
        !(net_clr && net_valid))
        else $error("net_clr and net_valid high together");

    // an unread result is not withdrawn
    res_hold: assert property (@(posedge clk) disable iff (!arstn)
        res_valid && !res_ready |=> res_valid)
        else $error("res_valid dropped without res_ready");

    // no spikes in the first cycle out of reset
    spk_quiet: assert property (@(posedge clk) $rose(arstn) |=> spikes == '0)
        else $error("spikes high right after reset");

endmodule

bind snn_top snn_checker u_checker (
    .clk(clk),
    .arstn(arstn),
    .src_valid(src_valid),
    .src_ready(src_ready),
    .src(src),
    .net_valid(net_valid),
    .net_clr(net_clr),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .spikes(spikes)
);

// File: hdl/snn_top.sv
`timescale 1ns/1ps

module snn_top (
    input  logic clk,
    input  logic arstn,
    // source words
    input  logic src_valid,
    output logic src_ready,
    input  snn_pkg::src_word_t src,
    // config writes
    input  logic cfg_we,
    input  snn_pkg::cfg_addr_t cfg_addr,
    input  snn_pkg::cfg_data_t cfg_wdata,
    // layer output
    output snn_pkg::spk_vec_t spikes,
    // spike count results
    input  logic res_ready,
    output logic res_valid,
    output snn_pkg::count_vec_t res_counts,
    output logic res_overrun
);

    logic net_valid;
    logic net_clr;
    logic out_ready;
    snn_pkg::charge_t net_inp [0:snn_pkg::NET_NUM_INP-1];
    snn_pkg::potential_t thresholds [0:snn_pkg::NET_NUM_OUT-1];
    snn_pkg::mask_t masks [0:snn_pkg::NET_NUM_OUT-1];

    // word decode and flag sequencing
    network_source u_source (
        .clk(clk),
        .arstn(arstn),
        .src_valid(src_valid),
        .src_ready(src_ready),
        .src(src),
        .out_ready(out_ready),
        .net_valid(net_valid),
        .net_clr(net_clr),
        .net_inp(net_inp)
    );

    // thresholds and masks steering the layer
    neuron_config_regs u_cfg (
        .clk(clk),
        .arstn(arstn),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .thresholds(thresholds),
        .masks(masks)
    );

    neuron_layer u_layer (
        .clk(clk),
        .arstn(arstn),
        .net_valid(net_valid),
        .net_clr(net_clr),
        .net_inp(net_inp),
        .thresholds(thresholds),
        .masks(masks),
        .spikes(spikes)
    );

    // dump words snapshot the counts through out_ready
    spike_counter u_counter (
        .clk(clk),
        .arstn(arstn),
        .spikes(spikes),
        .out_ready(out_ready),
        .res_ready(res_ready),
        .res_valid(res_valid),
        .res_counts(res_counts),
        .res_overrun(res_overrun)
    );

endmodule

// File: hdl/spike_counter.sv
`timescale 1ns/1ps

module spike_counter (
    input  logic clk,
    input  logic arstn,
    input  snn_pkg::spk_vec_t spikes,
    // snapshot strobe from the source
    input  logic out_ready,
    // result handshake
    input  logic res_ready,
    output logic res_valid,
    output snn_pkg::count_vec_t res_counts,
    output logic res_overrun
);

    snn_pkg::count_t cnt [0:snn_pkg::NET_NUM_OUT-1];
    snn_pkg::count_t cnt_next [0:snn_pkg::NET_NUM_OUT-1];

    // add one spike, sticking at the top count
    function automatic snn_pkg::count_t sat_inc(input snn_pkg::count_t c, input logic s);
        logic [snn_pkg::COUNT_WIDTH:0] w;
        w = {1'b0, c} + {{snn_pkg::COUNT_WIDTH{1'b0}}, s};
        return w[snn_pkg::COUNT_WIDTH] ? '1 : w[snn_pkg::COUNT_WIDTH-1:0];
    endfunction

    always_comb begin
        for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
            cnt_next[n] = sat_inc(cnt[n], spikes[n]);
        end
    end

    // counting restarts from zero after each snapshot
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                cnt[n] <= '0;
            end
        end else begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                cnt[n] <= out_ready ? snn_pkg::count_t'(0) : cnt_next[n];
            end
        end
    end

    // result handshake; an unread result being replaced is an overrun
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            res_valid <= 1'b0;
            res_overrun <= 1'b0;
        end else if (out_ready) begin
            res_valid <= 1'b1;
            if (res_valid && !res_ready) begin
                res_overrun <= 1'b1;
            end
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // snapshot includes the spikes of the strobe cycle itself
    always_ff @(posedge clk) begin
        if (out_ready) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                res_counts[n*snn_pkg::COUNT_WIDTH +: snn_pkg::COUNT_WIDTH] <= cnt_next[n];
            end
        end
    end

endmodule

// File: hdl/neuron_layer.sv
`timescale 1ns/1ps

module neuron_layer (
    input  logic clk,
    input  logic arstn,
    // input vector from the source
    input  logic net_valid,
    input  logic net_clr,
    input  snn_pkg::charge_t net_inp [0:snn_pkg::NET_NUM_INP-1],
    // config levels
    input  snn_pkg::potential_t thresholds [0:snn_pkg::NET_NUM_OUT-1],
    input  snn_pkg::mask_t masks [0:snn_pkg::NET_NUM_OUT-1],
    // one registered pulse per firing neuron
    output snn_pkg::spk_vec_t spikes
);

    snn_pkg::potential_t pot [0:snn_pkg::NET_NUM_OUT-1];
    snn_pkg::potential_t pot_next [0:snn_pkg::NET_NUM_OUT-1];
    logic signed [snn_pkg::SUM_WIDTH-1:0] acc [0:snn_pkg::NET_NUM_OUT-1];
    snn_pkg::spk_vec_t fire;

    // clamp the wide sum into the signed potential range
    function automatic snn_pkg::potential_t sat_pot(
        input logic signed [snn_pkg::SUM_WIDTH-1:0] v
    );
        logic [snn_pkg::SUM_WIDTH-snn_pkg::POT_WIDTH:0] top;
        top = v[snn_pkg::SUM_WIDTH-1:snn_pkg::POT_WIDTH-1];
        // all-equal top bits means the value already fits
        if (top == '0 || top == '1) begin
            return v[snn_pkg::POT_WIDTH-1:0];
        end else if (v[snn_pkg::SUM_WIDTH-1]) begin
            return {1'b1, {(snn_pkg::POT_WIDTH-1){1'b0}}};
        end else begin
            return {1'b0, {(snn_pkg::POT_WIDTH-1){1'b1}}};
        end
    endfunction

    // integrate the masked charges, then compare against the threshold
    always_comb begin
        for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
            acc[n] = pot[n];
            for (int i = 0; i < snn_pkg::NET_NUM_INP; i++) begin
                if (masks[n][i]) begin
                    acc[n] = acc[n] + net_inp[i];
                end
            end
            pot_next[n] = sat_pot(acc[n]);
            fire[n] = (pot_next[n] >= thresholds[n]);
        end
    end

    // clear wins, although the source never raises both
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                pot[n] <= '0;
            end
        end else if (net_clr) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                pot[n] <= '0;
            end
        end else if (net_valid) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                // a firing neuron restarts from zero
                pot[n] <= fire[n] ? snn_pkg::potential_t'(0) : pot_next[n];
            end
        end
    end

    // spikes only follow an accepted vector
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            spikes <= '0;
        end else begin
            spikes <= net_valid ? fire : '0;
        end
    end

endmodule

// File: hdl/neuron_config_regs.sv
`timescale 1ns/1ps

module neuron_config_regs (
    input  logic clk,
    input  logic arstn,
    // write port
    input  logic cfg_we,
    input  snn_pkg::cfg_addr_t cfg_addr,
    input  snn_pkg::cfg_data_t cfg_wdata,
    // levels towards the layer
    output snn_pkg::potential_t thresholds [0:snn_pkg::NET_NUM_OUT-1],
    output snn_pkg::mask_t masks [0:snn_pkg::NET_NUM_OUT-1]
);

    // address bit 2 picks the bank, low bits pick the neuron
    logic sel_mask;
    logic [1:0] sel_neuron;
    snn_pkg::potential_t thr_wdata;

    assign sel_mask = cfg_addr[2];
    assign sel_neuron = cfg_addr[1:0];

    // thresholds below one would let a neuron fire with no input
    always_comb begin
        if ($signed(cfg_wdata) < 1) begin
            thr_wdata = snn_pkg::potential_t'(1);
        end else begin
            thr_wdata = snn_pkg::potential_t'(cfg_wdata);
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int n = 0; n < snn_pkg::NET_NUM_OUT; n++) begin
                thresholds[n] <= snn_pkg::THRESH_RESET;
                masks[n] <= snn_pkg::MASK_RESET;
            end
        end else if (cfg_we) begin
            if (sel_mask) begin
                // only the low bits of the data carry the mask
                masks[sel_neuron] <= cfg_wdata[snn_pkg::NET_NUM_INP-1:0];
            end else begin
                thresholds[sel_neuron] <= thr_wdata;
            end
        end
    end

endmodule

// File: hdl/network_source.sv
`timescale 1ns/1ps

module network_source (
    input  logic clk,
    input  logic arstn,
    // upstream handshake
    input  logic src_valid,
    output logic src_ready,
    input  snn_pkg::src_word_t src,
    // snapshot strobe towards the counter
    output logic out_ready,
    // network side
    output logic net_valid,
    output logic net_clr,
    output snn_pkg::charge_t net_inp [0:snn_pkg::NET_NUM_INP-1]
);

    logic has_clr;
    logic has_dec;
    logic flagged;
    // high in the second cycle of a flagged word
    logic delay;

    assign has_clr = src[snn_pkg::FLAG_CLR];
    assign has_dec = src[snn_pkg::FLAG_DEC];
    assign flagged = has_clr | has_dec;

    // plain words pass straight through, flagged words wait one cycle
    assign net_valid = src_valid & (~flagged | delay);
    assign src_ready = ~flagged | delay;

    // the action of a flagged word happens in its first cycle
    assign net_clr = src_valid & has_clr & ~delay;
    assign out_ready = src_valid & has_dec & ~delay;

    // charge 0 sits right below the flags
    always_comb begin
        for (int i = 0; i < snn_pkg::NET_NUM_INP; i++) begin
            net_inp[i] = src[(snn_pkg::SRC_WIDTH - snn_pkg::OPC_WIDTH
                             - i * snn_pkg::NET_CHARGE_WIDTH - 1)
                             -: snn_pkg::NET_CHARGE_WIDTH];
        end
    end

    // set only for a valid flagged word, always cleared after the apply cycle
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            delay <= 1'b0;
        end else begin
            delay <= src_valid & flagged & ~delay;
        end
    end

endmodule

// File: hdl/snn_pkg.sv
package snn_pkg;

    // network dimensions
    localparam int NET_NUM_INP = 4;
    localparam int NET_NUM_OUT = 4;
    localparam int NET_CHARGE_WIDTH = 8;
    localparam int POT_WIDTH = 12;
    localparam int COUNT_WIDTH = 8;

    // source word: two flags on top, then the charges
    localparam int OPC_WIDTH = 2;
    localparam int SRC_WIDTH = OPC_WIDTH + NET_NUM_INP * NET_CHARGE_WIDTH;
    localparam int FLAG_CLR = SRC_WIDTH - 1;
    localparam int FLAG_DEC = SRC_WIDTH - 2;

    // integrator headroom, a full potential plus every charge at its extreme
    localparam int SUM_WIDTH = POT_WIDTH + 2;

    // config bus
    localparam int CFG_ADDR_WIDTH = 3;
    localparam int CFG_DATA_WIDTH = POT_WIDTH;

    typedef logic [SRC_WIDTH-1:0] src_word_t;
    typedef logic signed [NET_CHARGE_WIDTH-1:0] charge_t;
    typedef logic signed [POT_WIDTH-1:0] potential_t;
    // bit i connects input i
    typedef logic [NET_NUM_INP-1:0] mask_t;
    typedef logic [NET_NUM_OUT-1:0] spk_vec_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    // neuron 0 in the low byte
    typedef logic [NET_NUM_OUT*COUNT_WIDTH-1:0] count_vec_t;
    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;

    // config reset values
    localparam potential_t THRESH_RESET = 12'sd64;
    // every input connected
    localparam mask_t MASK_RESET = '1;

endpackage
